/* hw/core_cfg_pkg.sv */
package core_cfg_pkg;

	// stream and word geometry
	localparam int BYTE_W = 8;
	localparam int WORD_BYTES = 3; // bytes per beatmap word
	localparam int WORD_W = BYTE_W * WORD_BYTES;

	// beatmap memory
	localparam int ADDR_W = 13;
	localparam int MEM_DEPTH = 2 ** ADDR_W;

	// difficulty sections in the beatmap
	localparam int SECTION_COUNT = 4;
	localparam int SECTION_SEL_W = 2;

	// song samples
	localparam int SAMPLE_W = 8;

	// 100 MHz core clock over 44.1 kHz sample rate
	localparam int DEFAULT_TICK_PERIOD = 2267;

	// 1.5 s of silence before the song starts
	localparam int DEFAULT_PLAY_DELAY = 66150;

endpackage

/* hw/core_state_pkg.sv */
package core_state_pkg;

	// top level sequencer
	typedef enum logic [1:0] {
		CORE_RESET,
		CORE_LOAD,
		CORE_SCAN,
		CORE_PLAY
	} core_state_e;

	// header chain walk, one section per pass
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_READ,
		SCAN_WAIT, // stb out, waiting for ack
		SCAN_STORE
	} scan_state_e;

endpackage

/* hw/wb_mem_if.sv */
// Wishbone classic, word addressed beatmap access
interface wb_mem_if;

	logic cyc;
	logic stb;
	logic we;
	logic [core_cfg_pkg::ADDR_W-1:0] adr;
	logic [core_cfg_pkg::WORD_W-1:0] dat_w;
	logic [core_cfg_pkg::WORD_W-1:0] dat_r; // valid in the ack cycle
	logic ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

/* hw/section_loader.sv */
module section_loader (
	input logic CLK,
	input logic RESET_L,
	input logic load_start,
	input logic [core_cfg_pkg::BYTE_W-1:0] pre_data,
	input logic pre_data_ready,
	input logic pre_transmit_finished,
	output logic pre_restart,
	output logic pre_request_data,
	output logic load_done,
	wb_mem_if.master wr
);

	logic streaming;
	logic [$clog2(core_cfg_pkg::WORD_BYTES)-1:0] byte_cnt;
	logic take;

	// no new byte while a word write is still out
	assign pre_request_data = streaming && !wr.stb;
	assign take = pre_request_data && pre_data_ready && !pre_transmit_finished;
	assign wr.we = 1'b1;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			pre_restart <= 1'b0;
			streaming <= 1'b0;
			load_done <= 1'b0;
			byte_cnt <= '0;
			wr.cyc <= 1'b0;
			wr.stb <= 1'b0;
			wr.adr <= '0;
		end else begin
			pre_restart <= load_start;
			load_done <= 1'b0;
			if (pre_restart) begin
				streaming <= 1'b1;
				byte_cnt <= '0;
				wr.adr <= '0;
			end
			if (wr.ack) begin
				wr.cyc <= 1'b0;
				wr.stb <= 1'b0;
				wr.adr <= wr.adr + 1'b1; // next word slot
			end
			if (pre_request_data && pre_transmit_finished) begin
				streaming <= 1'b0; // partial word is dropped
				load_done <= 1'b1;
			end else if (take) begin
				if (byte_cnt == core_cfg_pkg::WORD_BYTES - 1) begin
					byte_cnt <= '0;
					wr.cyc <= 1'b1;
					wr.stb <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// lsb first packing
	always_ff @(posedge CLK) begin
		if (take)
			wr.dat_w[byte_cnt * core_cfg_pkg::BYTE_W +: core_cfg_pkg::BYTE_W] <= pre_data;
	end

endmodule

/* hw/beatmap_ram.sv */
module beatmap_ram (
	input logic CLK,
	input logic RESET_L,
	wb_mem_if.slave wr,
	wb_mem_if.slave rd
);

	logic [core_cfg_pkg::WORD_W-1:0] mem [core_cfg_pkg::MEM_DEPTH];

	assign wr.dat_r = '0; // port A is write only

	// port A write, once per request
	always_ff @(posedge CLK) begin
		if (wr.cyc && wr.stb && wr.we && !wr.ack)
			mem[wr.adr] <= wr.dat_w;
	end

	// port B registered read
	always_ff @(posedge CLK) begin
		if (rd.cyc && rd.stb)
			rd.dat_r <= mem[rd.adr];
	end

	// one cycle ack per request on each port
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			wr.ack <= 1'b0;
			rd.ack <= 1'b0;
		end else begin
			wr.ack <= wr.cyc && wr.stb && !wr.ack;
			rd.ack <= rd.cyc && rd.stb && !rd.ack;
		end
	end

endmodule

/* hw/section_scanner.sv */
module section_scanner (
	input logic CLK,
	input logic RESET_L,
	input logic scan_start,
	input logic [core_cfg_pkg::SECTION_SEL_W-1:0] section_sel,
	output logic scan_done,
	output logic [core_cfg_pkg::ADDR_W-1:0] section_base,
	output logic [core_cfg_pkg::ADDR_W-1:0] section_size,
	wb_mem_if.master rd
);

	core_state_pkg::scan_state_e scan_state;
	logic [core_cfg_pkg::SECTION_SEL_W-1:0] idx;
	logic [core_cfg_pkg::ADDR_W-1:0] hdr_adr; // header word of section idx
	logic [core_cfg_pkg::ADDR_W-1:0] size_tab [core_cfg_pkg::SECTION_COUNT];
	logic [core_cfg_pkg::ADDR_W-1:0] base_tab [core_cfg_pkg::SECTION_COUNT];

	// request held from READ until the ack in WAIT
	assign rd.cyc = scan_state == core_state_pkg::SCAN_READ ||
		scan_state == core_state_pkg::SCAN_WAIT;
	assign rd.stb = rd.cyc;
	assign rd.we = 1'b0;
	assign rd.adr = hdr_adr;
	assign rd.dat_w = '0;

	assign section_base = base_tab[section_sel];
	assign section_size = size_tab[section_sel];

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			scan_state <= core_state_pkg::SCAN_IDLE;
			idx <= '0;
			hdr_adr <= '0;
			scan_done <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			case (scan_state)
				core_state_pkg::SCAN_IDLE: if (scan_start) begin
					idx <= '0;
					hdr_adr <= '0;
					scan_state <= core_state_pkg::SCAN_READ;
				end
				core_state_pkg::SCAN_READ: scan_state <= core_state_pkg::SCAN_WAIT;
				core_state_pkg::SCAN_WAIT: if (rd.ack)
					scan_state <= core_state_pkg::SCAN_STORE;
				core_state_pkg::SCAN_STORE: begin
					hdr_adr <= hdr_adr + size_tab[idx] + 1'b1; // next header
					idx <= idx + 1'b1;
					if (idx == core_cfg_pkg::SECTION_COUNT - 1) begin
						scan_state <= core_state_pkg::SCAN_IDLE;
						scan_done <= 1'b1;
					end else begin
						scan_state <= core_state_pkg::SCAN_READ;
					end
				end
				default: scan_state <= core_state_pkg::SCAN_IDLE;
			endcase
		end
	end

	// section table
	always_ff @(posedge CLK) begin
		if (scan_state == core_state_pkg::SCAN_WAIT && rd.ack)
			size_tab[idx] <= rd.dat_r[core_cfg_pkg::ADDR_W-1:0];
		if (scan_state == core_state_pkg::SCAN_STORE)
			base_tab[idx] <= hdr_adr + 1'b1; // data starts past the header
	end

endmodule

/* hw/audio_pacer.sv */
module audio_pacer #(
	parameter int TICK_PERIOD = core_cfg_pkg::DEFAULT_TICK_PERIOD,
	parameter int PLAY_DELAY = core_cfg_pkg::DEFAULT_PLAY_DELAY
) (
	input logic CLK,
	input logic RESET_L,
	input logic play_on,
	input logic [core_cfg_pkg::SAMPLE_W-1:0] song_data,
	input logic song_data_ready,
	output logic song_request_data,
	output logic [core_cfg_pkg::SAMPLE_W-1:0] audio_out
);

	logic [$clog2(TICK_PERIOD)-1:0] tick_cnt;
	logic [$clog2(PLAY_DELAY + 1)-1:0] delay_cnt; // silent ticks so far
	logic tick_end;

	assign tick_end = play_on && tick_cnt == TICK_PERIOD - 1;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			tick_cnt <= '0;
			delay_cnt <= '0;
			song_request_data <= 1'b0;
		end else begin
			if (play_on)
				tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
			if (tick_end && delay_cnt < PLAY_DELAY)
				delay_cnt <= delay_cnt + 1'b1;
			// one request per tick once the delay is over
			song_request_data <= tick_end && delay_cnt == PLAY_DELAY;
		end
	end

	// sample source has no back-pressure, take whatever arrives
	always_ff @(posedge CLK) begin
		if (!RESET_L)
			audio_out <= '0;
		else if (song_data_ready)
			audio_out <= song_data;
	end

endmodule

/* hw/game_core.sv */
module game_core #(
	parameter int TICK_PERIOD = core_cfg_pkg::DEFAULT_TICK_PERIOD,
	parameter int PLAY_DELAY = core_cfg_pkg::DEFAULT_PLAY_DELAY
) (
	input logic CLK,
	input logic RESET_L,
	input logic [core_cfg_pkg::BYTE_W-1:0] pre_data,
	input logic pre_data_ready,
	input logic pre_transmit_finished,
	input logic [core_cfg_pkg::SAMPLE_W-1:0] song_data,
	input logic song_data_ready,
	input logic [core_cfg_pkg::SECTION_SEL_W-1:0] section_sel,
	output logic pre_restart,
	output logic pre_request_data,
	output logic song_request_data,
	output logic [core_cfg_pkg::SAMPLE_W-1:0] audio_out,
	output logic audio_en,
	output logic [core_cfg_pkg::ADDR_W-1:0] section_base,
	output logic [core_cfg_pkg::ADDR_W-1:0] section_size,
	output core_state_pkg::core_state_e core_state
);

	logic load_start;
	logic load_done;
	logic scan_start;
	logic scan_done;
	logic play_on;

	wb_mem_if wr_bus ();
	wb_mem_if rd_bus ();

	assign play_on = core_state == core_state_pkg::CORE_PLAY;
	assign audio_en = play_on;

	// reset -> load -> scan -> play, play is final
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			core_state <= core_state_pkg::CORE_RESET;
			load_start <= 1'b0;
			scan_start <= 1'b0;
		end else begin
			load_start <= 1'b0;
			scan_start <= 1'b0;
			case (core_state)
				core_state_pkg::CORE_RESET: begin
					core_state <= core_state_pkg::CORE_LOAD;
					load_start <= 1'b1;
				end
				core_state_pkg::CORE_LOAD: if (load_done) begin
					core_state <= core_state_pkg::CORE_SCAN;
					scan_start <= 1'b1;
				end
				core_state_pkg::CORE_SCAN: if (scan_done)
					core_state <= core_state_pkg::CORE_PLAY;
				default: core_state <= core_state_pkg::CORE_PLAY;
			endcase
		end
	end

	section_loader loader_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.load_start(load_start),
		.pre_data(pre_data),
		.pre_data_ready(pre_data_ready),
		.pre_transmit_finished(pre_transmit_finished),
		.pre_restart(pre_restart),
		.pre_request_data(pre_request_data),
		.load_done(load_done),
		.wr(wr_bus.master)
	);

	beatmap_ram ram_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.wr(wr_bus.slave),
		.rd(rd_bus.slave)
	);

	section_scanner scanner_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.scan_start(scan_start),
		.section_sel(section_sel),
		.scan_done(scan_done),
		.section_base(section_base),
		.section_size(section_size),
		.rd(rd_bus.master)
	);

	audio_pacer #(
		.TICK_PERIOD(TICK_PERIOD),
		.PLAY_DELAY(PLAY_DELAY)
	) pacer_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.play_on(play_on),
		.song_data(song_data),
		.song_data_ready(song_data_ready),
		.song_request_data(song_request_data),
		.audio_out(audio_out)
	);

endmodule

/* sim/game_core_sva.sv */
module game_core_sva (
	input logic CLK,
	input logic RESET_L,
	input logic song_request_data,
	input logic audio_en,
	input core_state_pkg::core_state_e core_state,
	input logic wr_stb,
	input logic wr_ack,
	input logic rd_stb,
	input logic rd_ack
);

	int err_cnt = 0; // failed assertions so far

	// one request per tick
	assert property (@(posedge CLK) disable iff (!RESET_L)
		song_request_data |=> !song_request_data)
		else begin
			$error("song_request_data high two cycles in a row");
			err_cnt++;
		end

	assert property (@(posedge CLK) disable iff (!RESET_L) wr_ack |-> $past(wr_stb))
		else begin
			$error("wr_bus ack without a strobe the cycle before");
			err_cnt++;
		end
	assert property (@(posedge CLK) disable iff (!RESET_L) rd_ack |-> $past(rd_stb))
		else begin
			$error("rd_bus ack without a strobe the cycle before");
			err_cnt++;
		end

	assert property (@(posedge CLK) disable iff (!RESET_L)
		audio_en |-> core_state == core_state_pkg::CORE_PLAY)
		else begin
			$error("audio_en high outside CORE_PLAY");
			err_cnt++;
		end

endmodule

/* sim/game_core_tb.sv */
module game_core_tb;

	localparam int TICK = 20;
	localparam int DELAY = 4;
	localparam int PERIOD = 10;
	localparam int REQ_COUNT = 6;

	logic CLK = 1'b0;
	logic RESET_L;
	logic [core_cfg_pkg::BYTE_W-1:0] pre_data;
	logic pre_data_ready;
	logic pre_transmit_finished;
	logic [core_cfg_pkg::SAMPLE_W-1:0] song_data;
	logic song_data_ready;
	logic [core_cfg_pkg::SECTION_SEL_W-1:0] section_sel;
	logic pre_restart;
	logic pre_request_data;
	logic song_request_data;
	logic [core_cfg_pkg::SAMPLE_W-1:0] audio_out;
	logic audio_en;
	logic [core_cfg_pkg::ADDR_W-1:0] section_base;
	logic [core_cfg_pkg::ADDR_W-1:0] section_size;
	core_state_pkg::core_state_e core_state;

	logic [31:0] seed = 32'h946d;
	int sizes [core_cfg_pkg::SECTION_COUNT];
	logic [core_cfg_pkg::BYTE_W-1:0] stream [$]; // beatmap image as bytes
	int byte_idx = 0;
	int resp_wait = 0;
	int samples_sent = 0;
	logic [core_cfg_pkg::SAMPLE_W-1:0] exp_audio = '0;
	int restart_cnt = 0;
	logic req_seen = 1'b0;
	logic in_play = 1'b0;

	game_core #(.TICK_PERIOD(TICK), .PLAY_DELAY(DELAY)) game_core_i (.*);

	bind game_core game_core_sva sva_i (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.song_request_data(song_request_data),
		.audio_en(audio_en),
		.core_state(core_state),
		.wr_stb(wr_bus.stb),
		.wr_ack(wr_bus.ack),
		.rd_stb(rd_bus.stb),
		.rd_ack(rd_bus.ack)
	);

	always #(PERIOD / 2) CLK = ~CLK;

	// lcg step keeps the upper bits
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed >> 8;
	endfunction

	// section k data starts one word past its header
	function automatic int expected_base(input int k);
		int b;
		b = 1;
		for (int i = 0; i < k; i++)
			b = b + sizes[i] + 1;
		return b;
	endfunction

	task automatic push_word(input logic [core_cfg_pkg::WORD_W-1:0] word);
		for (int b = 0; b < core_cfg_pkg::WORD_BYTES; b++)
			stream.push_back(word[b * core_cfg_pkg::BYTE_W +: core_cfg_pkg::BYTE_W]); // lsb first
	endtask

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		fail_now($sformatf("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got));
	endtask

	// pre-read source with random one cycle gaps
	always @(negedge CLK) begin
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
		if (pre_request_data) begin
			if (byte_idx == stream.size()) begin
				pre_transmit_finished = 1'b1;
			end else if (next_rand() % 4 != 0) begin
				pre_data_ready = 1'b1;
				pre_data = stream[byte_idx];
				byte_idx++;
			end
		end
	end

	// song source answers each request a few cycles later
	always @(negedge CLK) begin
		song_data_ready = 1'b0;
		if (song_request_data) begin
			resp_wait = 1 + next_rand() % 8;
		end else if (resp_wait > 0) begin
			resp_wait--;
			if (resp_wait == 0) begin
				song_data_ready = 1'b1;
				song_data = 8'(next_rand());
				samples_sent++;
			end
		end
	end

	always @(posedge CLK)
		if (song_data_ready)
			exp_audio <= song_data;

	always @(negedge CLK) begin
		assert (game_core_i.sva_i.err_cnt == 0) else
			fail_now("a bound concurrent assertion failed");
		assert (audio_out == exp_audio) else report_mismatch("audio_out", exp_audio, audio_out);
		if (!req_seen && pre_request_data) begin
			req_seen = 1'b1;
			assert (restart_cnt == 1) else report_mismatch("pre_restart pulses", 1, restart_cnt);
		end
		if (pre_restart)
			restart_cnt++;
		if (core_state == core_state_pkg::CORE_PLAY)
			in_play = 1'b1;
		if (in_play) begin
			assert (core_state == core_state_pkg::CORE_PLAY && audio_en) else
				fail_now("core left CORE_PLAY or audio_en dropped during play");
		end else begin
			assert (!audio_en) else report_mismatch("audio_en", 0, audio_en);
		end
	end

	initial begin
		int n;
		int off;
		int last;
		time play_t;
		RESET_L = 1'b0;
		pre_data = '0;
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data = '0;
		song_data_ready = 1'b0;
		section_sel = '0;

		// header word then filler words per section
		foreach (sizes[k]) begin
			sizes[k] = 1 + next_rand() % 6;
			push_word(sizes[k]);
			repeat (sizes[k])
				push_word(next_rand());
		end
		stream.push_back(8'ha5); // trailing partial word is never written
		stream.push_back(8'h5a);

		repeat (10) begin
			@(negedge CLK);
			assert (!pre_restart && !pre_request_data && !song_request_data && !audio_en) else
				fail_now("a stream or audio output is active during reset");
			assert (core_state == core_state_pkg::CORE_RESET) else
				report_mismatch("core_state", core_state_pkg::CORE_RESET, core_state);
		end
		RESET_L = 1'b1;

		n = 0;
		while (core_state != core_state_pkg::CORE_PLAY) begin
			@(negedge CLK);
			n++;
			if (n > 5000)
				fail_now("core_state never reached CORE_PLAY");
		end
		play_t = $time;

		for (int k = 0; k < core_cfg_pkg::SECTION_COUNT; k++) begin
			section_sel = k;
			@(negedge CLK);
			assert (section_base == expected_base(k)) else
				report_mismatch("section_base", expected_base(k), section_base);
			assert (section_size == sizes[k]) else
				report_mismatch("section_size", sizes[k], section_size);
			assert (!song_request_data) else fail_now("song request during the play delay");
		end

		last = 0;
		for (int r = 0; r < REQ_COUNT; r++) begin
			n = 0;
			do begin
				@(negedge CLK);
				n++;
				if (n > (DELAY + 2) * TICK)
					fail_now("no song_request_data pulse in time");
			end while (!song_request_data);
			off = ($time - play_t) / PERIOD; // cycles since play entry
			if (r == 0) begin
				assert (off > DELAY * TICK && off <= (DELAY + 1) * TICK) else
					report_mismatch("first song_request_data cycle", (DELAY + 1) * TICK, off);
			end else begin
				assert (off - last == TICK) else
					report_mismatch("song_request_data spacing", TICK, off - last);
			end
			last = off;
		end

		n = 0;
		while (samples_sent < REQ_COUNT) begin
			@(negedge CLK);
			n++;
			if (n > TICK)
				fail_now("last song sample was never sent");
		end
		repeat (2) @(negedge CLK); // audio monitor sees the last sample
		if (game_core_i.sva_i.err_cnt != 0) begin
			fail_now("a bound concurrent assertion failed");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

/* game_core.f */
hw/core_cfg_pkg.sv
hw/core_state_pkg.sv
hw/wb_mem_if.sv
hw/section_loader.sv
hw/beatmap_ram.sv
hw/section_scanner.sv
hw/audio_pacer.sv
hw/game_core.sv
sim/game_core_sva.sv
sim/game_core_tb.sv

/* Bender.yml */
package:
  name: game_core

sources:
  - hw/core_cfg_pkg.sv
  - hw/core_state_pkg.sv
  - hw/wb_mem_if.sv
  - hw/section_loader.sv
  - hw/beatmap_ram.sv
  - hw/section_scanner.sv
  - hw/audio_pacer.sv
  - hw/game_core.sv
  - target: simulation
    files:
      - sim/game_core_sva.sv
      - sim/game_core_tb.sv
